/* hdl/column_arbiter.sv */
// Once-per-pass lowest-first column arbiter with one-cycle grants, served mask and release flag
`timescale 1ns/1ps

module column_arbiter
#(
    parameter int COLS = lib_arbiter_pkg::LVL0_COLS       // Number of columns arbitrated
)
(
    input  logic                          clk_i,          // Clock
    input  logic                          reset_i,        // Async reset, active high
    input  logic                          enable_i,       // Grants allowed
    input  logic                          refresh_i,      // Start of a new row or pass
    input  logic [COLS-1:0]               req_i,          // Column requests of the held row
    output logic [COLS-1:0]               gnt_o,          // One-hot column grant
    output lib_arbiter_pkg::arb_result_t  res_o           // Valid, index and release
);

    localparam int AW = lib_arbiter_pkg::LVL0_ADD;        // Index width

    logic [COLS-1:0] served_q;                            // Columns served in this row
    logic [COLS-1:0] gnt_q;                               // Registered one-hot grant
    logic [AW-1:0]   idx_q;                               // Index of the granted column
    logic [COLS-1:0] open_c;                              // Requesting and not marked served
    logic [COLS-1:0] pend_c;                              // Open and not granted right now
    logic [COLS-1:0] pick_c;                              // Lowest pending column, one-hot
    logic [AW-1:0]   pick_idx_c;                          // Index of the lowest pending column
    logic            found_c;                             // Some column is pending

    assign open_c = req_i & ~served_q;
    assign pend_c = open_c & ~gnt_q;                      // Current grant is marked on this edge

    // Lowest-first priority pick
    always_comb
    begin
        pick_c     = '0;
        pick_idx_c = '0;
        found_c    = 1'b0;
        for (int j = 0; j < COLS; j++)
        begin
            if (pend_c[j] && !found_c)                    // First pending column wins
            begin
                found_c    = 1'b1;
                pick_c[j]  = 1'b1;
                pick_idx_c = j[AW-1:0];
            end
        end
    end

    // Every grant lasts exactly one cycle
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            served_q <= '0;
            gnt_q    <= '0;
            idx_q    <= '0;
        end
        else if (refresh_i)
        begin
            served_q <= '0;                               // Fresh mask for the next row
            gnt_q    <= '0;
        end
        else
        begin
            served_q <= served_q | gnt_q;                 // Column done once its cycle passed
            if (enable_i && found_c)
            begin
                gnt_q <= pick_c;                          // Next column in ascending order
                idx_q <= pick_idx_c;
            end
            else
                gnt_q <= '0;                              // Disabled or nothing left
        end
    end

    assign gnt_o = gnt_q;

    assign res_o = '{valid:       |gnt_q,
                     index:       idx_q,
                     grp_release: ~|open_c};              // Row fully served

    // At most one column granted
    a_col_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o));

    // A disabled cycle never produces a grant on the next one
    a_col_no_gnt_off: assert property (@(posedge clk_i) disable iff (reset_i)
        !enable_i |=> (gnt_o == '0));

endmodule

/* hdl/lib_arbiter_pkg.sv */
// Shared array sizes, address width, pixel address struct and arbiter result struct
package lib_arbiter_pkg;

    // Default group geometry
    localparam int LVL0_ROWS = 4;                 // Rows in one pixel group
    localparam int LVL0_COLS = 4;                 // Columns in one pixel group
    localparam int LVL0_ADD  = 2;                 // Bits of a row or column index

    // Address of the pixel currently granted
    typedef struct packed
    {
        logic [LVL0_ADD-1:0] x;                   // Row index
        logic [LVL0_ADD-1:0] y;                   // Column index
    } pixel_addr_t;

    // Status returned by the row and the column arbiter
    typedef struct packed
    {
        logic                valid;               // Grant held this cycle
        logic [LVL0_ADD-1:0] index;               // Position that holds the grant
        logic                grp_release;         // No requesting position left unserved
    } arb_result_t;

endpackage

/* hdl/pixel_level_0.sv */
// Pixel group arbiter top with request reduction, row/column FSM, grant matrix and status outputs
`timescale 1ns/1ps

module pixel_level_0
#(
    parameter int ROWS = lib_arbiter_pkg::LVL0_ROWS,      // Rows in the group
    parameter int COLS = lib_arbiter_pkg::LVL0_COLS       // Columns in the group
)
(
    input  logic                          clk_i,          // Clock
    input  logic                          reset_i,        // Async reset, active high
    input  logic                          enable_i,       // Pass runs while high
    input  logic [ROWS-1:0][COLS-1:0]     req_i,          // Pixel request levels
    output logic [ROWS-1:0][COLS-1:0]     gnt_o,          // One-hot pixel grant
    output lib_arbiter_pkg::pixel_addr_t  addr_o,         // Row and column of the grant
    output logic                          active_o,       // Column grant seen last cycle
    output logic                          req_o,          // Any pixel requesting
    output logic                          grp_release_o   // All requesting rows served
);

    // Both sizes must fit the address fields of the structs
    if (ROWS > (1 << lib_arbiter_pkg::LVL0_ADD) || COLS > (1 << lib_arbiter_pkg::LVL0_ADD))
    begin : g_size_check
        $error("ROWS and COLS must fit in LVL0_ADD address bits");
    end

    typedef enum logic [1:0]
    {
        IDLE      = 2'b00,                                // Waiting for enable
        ROW_GRANT = 2'b01,                                // Looking for the next row
        COL_GRANT = 2'b10                                 // Walking the columns of a row
    } state_t;

    state_t state_q;                                      // Current FSM state
    state_t state_d;                                      // Next FSM state

    logic [ROWS-1:0] row_req;                             // OR of each row
    logic [COLS-1:0] col_req;                             // Columns of the held row
    logic [ROWS-1:0] x_gnt;                               // Row arbiter grant
    logic [COLS-1:0] y_gnt;                               // Column arbiter grant
    logic            x_enable;                            // Row arbiter may grant or release
    logic            y_enable;                            // Column arbiter may grant
    logic            refresh_x;                           // New pass for the row arbiter
    logic            refresh_y;                           // New row or pass for the column arbiter

    lib_arbiter_pkg::arb_result_t res_x;                  // Row arbiter status
    lib_arbiter_pkg::arb_result_t res_y;                  // Column arbiter status

    assign req_o = |req_i;                                // Group request towards higher level

    // Row requests
    always_comb
    begin
        for (int i = 0; i < ROWS; i++)
            row_req[i] = |req_i[i];
    end

    // Column requests only exist while a row is held
    always_comb
    begin
        if (res_x.valid)
            col_req = req_i[res_x.index];
        else
            col_req = '0;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    // FSM next state and arbiter controls
    always_comb
    begin
        state_d   = state_q;
        x_enable  = 1'b0;
        y_enable  = 1'b0;
        refresh_x = ~enable_i;                            // Low enable clears both passes
        refresh_y = ~enable_i;
        if (!enable_i)
            state_d = IDLE;
        else
        begin
            case (state_q)
                IDLE:
                begin
                    x_enable = 1'b1;                      // Pick the first row right away
                    state_d  = ROW_GRANT;
                end
                ROW_GRANT:
                begin
                    if (|x_gnt)
                    begin
                        y_enable = 1'b1;                  // Row held so the first column comes next
                        state_d  = COL_GRANT;
                    end
                    else
                        x_enable = 1'b1;                  // Keep looking for a row
                end
                COL_GRANT:
                begin
                    if (res_y.valid)
                        y_enable = 1'b1;                  // More columns may follow
                    else
                    begin
                        x_enable  = 1'b1;                 // Row arbiter marks the row served
                        refresh_y = 1'b1;                 // Clean column mask for next row
                        state_d   = ROW_GRANT;
                    end
                end
                default:
                    state_d = IDLE;
            endcase
        end
    end

    // Grant matrix from the two one-hot grants
    always_comb
    begin
        for (int i = 0; i < ROWS; i++)
            for (int j = 0; j < COLS; j++)
                gnt_o[i][j] = enable_i & x_gnt[i] & y_gnt[j];   // Single bit at row and column
    end

    assign addr_o = '{x: res_x.index, y: res_y.index};    // Valid while gnt_o has a bit set

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            active_o      <= 1'b0;
            grp_release_o <= 1'b0;
        end
        else
        begin
            active_o      <= |gnt_o;                      // One cycle behind the pixel grant
            grp_release_o <= enable_i & res_x.grp_release & res_y.grp_release;
        end
    end

    row_arbiter
    #(
        .ROWS (ROWS)
    )
    RRA_X
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .enable_i  (x_enable),
        .refresh_i (refresh_x),
        .req_i     (row_req),
        .gnt_o     (x_gnt),
        .res_o     (res_x)
    );

    column_arbiter
    #(
        .COLS (COLS)
    )
    RRA_Y
    (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .enable_i  (y_enable),
        .refresh_i (refresh_y),
        .req_i     (col_req),
        .gnt_o     (y_gnt),
        .res_o     (res_y)
    );

    // Row and column arbiters together never grant more than one pixel
    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o));

    // A granted pixel was requesting on the edge that made the grant
    a_gnt_req: assert property (@(posedge clk_i) disable iff (reset_i)
        (gnt_o & ~$past(req_i)) == '0);

endmodule

/* hdl/row_arbiter.sv */
// Once-per-pass lowest-first row arbiter with served mask and release flag
`timescale 1ns/1ps

module row_arbiter
#(
    parameter int ROWS = lib_arbiter_pkg::LVL0_ROWS       // Number of rows arbitrated
)
(
    input  logic                          clk_i,          // Clock
    input  logic                          reset_i,        // Async reset, active high
    input  logic                          enable_i,       // Grant or release allowed
    input  logic                          refresh_i,      // Start a new pass
    input  logic [ROWS-1:0]               req_i,          // One request bit per row
    output logic [ROWS-1:0]               gnt_o,          // One-hot row grant
    output lib_arbiter_pkg::arb_result_t  res_o           // Valid, index and release
);

    localparam int AW = lib_arbiter_pkg::LVL0_ADD;        // Index width

    logic [ROWS-1:0] served_q;                            // Rows already served this pass
    logic [ROWS-1:0] gnt_q;                               // Registered one-hot grant
    logic [AW-1:0]   idx_q;                               // Index of the granted row
    logic [ROWS-1:0] pend_c;                              // Requesting and not yet served
    logic [ROWS-1:0] pick_c;                              // Lowest pending row, one-hot
    logic [AW-1:0]   pick_idx_c;                          // Index of the lowest pending row
    logic            found_c;                             // Some row is pending

    assign pend_c = req_i & ~served_q;                    // Candidates for this pass

    // Lowest-first priority pick
    always_comb
    begin
        pick_c     = '0;
        pick_idx_c = '0;
        found_c    = 1'b0;
        for (int i = 0; i < ROWS; i++)
        begin
            if (pend_c[i] && !found_c)                    // First pending row wins
            begin
                found_c    = 1'b1;
                pick_c[i]  = 1'b1;
                pick_idx_c = i[AW-1:0];
            end
        end
    end

    // Grant is held while disabled and dropped on the next enabled cycle
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            served_q <= '0;                               // Nothing served after reset
            gnt_q    <= '0;
            idx_q    <= '0;
        end
        else if (refresh_i)
        begin
            served_q <= '0;                               // New pass makes every row eligible again
            gnt_q    <= '0;
        end
        else if (enable_i)
        begin
            if (|gnt_q)
            begin
                served_q <= served_q | gnt_q;             // Row done and never again this pass
                gnt_q    <= '0;
            end
            else if (found_c)
            begin
                gnt_q <= pick_c;                          // Take the lowest pending row
                idx_q <= pick_idx_c;
            end
        end
    end

    assign gnt_o = gnt_q;

    assign res_o = '{valid:       |gnt_q,
                     index:       idx_q,
                     grp_release: ~|pend_c};              // Release once no row is left

    // At most one row granted
    a_row_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(gnt_o));

    // A new row grant goes to a row that was requesting on the grant edge
    a_row_req: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(res_o.valid) |-> |(gnt_o & $past(req_i)));

endmodule

/* list.f */
hdl/lib_arbiter_pkg.sv
hdl/row_arbiter.sv
hdl/column_arbiter.sv
hdl/pixel_level_0.sv
tests/pixel_level_0_tb.sv

/* tests/pixel_level_0_tb.sv */
// Testbench for pixel_level_0 with clock, reset, trace reader, pixel model, rule model and checks
`timescale 1ns/1ps

module pixel_level_0_tb;

    localparam int ROWS     = lib_arbiter_pkg::LVL0_ROWS;    // Group rows
    localparam int COLS     = lib_arbiter_pkg::LVL0_COLS;    // Group columns
    localparam int AW       = lib_arbiter_pkg::LVL0_ADD;     // Index width
    localparam int WAIT_MAX = 40;                            // Cycle limit of each wait

    typedef logic [ROWS-1:0][COLS-1:0] gnt_mat_t;            // Shape of req_i and gnt_o

    logic                         clk_i;
    logic                         reset_i;
    logic                         enable_i;
    gnt_mat_t                     req_i;
    gnt_mat_t                     gnt_o;
    lib_arbiter_pkg::pixel_addr_t addr_o;
    logic                         active_o;
    logic                         req_o;
    logic                         grp_release_o;

    string                        test_name;                 // Scenario under test
    gnt_mat_t                     start_pat;                 // Requests when the scenario starts
    int                           drop_at;                   // Grant count that drops enable
    int                           late_at[$];                // Grant count of each late request
    gnt_mat_t                     late_pat[$];               // Pixels added at that count
    lib_arbiter_pkg::pixel_addr_t exp_q[$];                  // Grant order from the trace
    lib_arbiter_pkg::pixel_addr_t model_q[$];                // Grant order rebuilt from the rule
    int                           pass_end[$];               // Grant counts that close a pass
    gnt_mat_t                     gnt_s;                     // Samples taken on the falling edge
    lib_arbiter_pkg::pixel_addr_t addr_s;
    logic                         act_s;
    logic                         rel_s;

    pixel_level_0
    #(
        .ROWS (ROWS),
        .COLS (COLS)
    )
    UUT
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .gnt_o         (gnt_o),
        .addr_o        (addr_o),
        .active_o      (active_o),
        .req_o         (req_o),
        .grp_release_o (grp_release_o)
    );

    always #10 clk_i = ~clk_i;                               // 20 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_addr(input string what, input lib_arbiter_pkg::pixel_addr_t exp_v,
                              input lib_arbiter_pkg::pixel_addr_t act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("FAILED %s: %s expected (%0d,%0d) actual (%0d,%0d)",
                                test_name, what, exp_v.x, exp_v.y, act_v.x, act_v.y));
    endtask

    task automatic check_gnt(input string what, input gnt_mat_t exp_v, input gnt_mat_t act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("FAILED %s: %s expected %h actual %h",
                                test_name, what, exp_v, act_v));
    endtask

    task automatic check_bit(input string what, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
            abort_run($sformatf("FAILED %s: %s expected %b actual %b",
                                test_name, what, exp_v, act_v));
    endtask

    function automatic gnt_mat_t onehot_of(input lib_arbiter_pkg::pixel_addr_t a);
        gnt_mat_t m;
        m = '0;
        m[a.x][a.y] = 1'b1;
        return m;
    endfunction

    // One clock with samples first and then the reaction of the granted pixel
    task automatic step();
        @(negedge clk_i);
        act_s = active_o;
        check_bit("active_o", |gnt_s && enable_i, act_s);    // Follows the pixel grant by a cycle
        gnt_s  = gnt_o;
        addr_s = addr_o;
        rel_s  = grp_release_o;
        check_bit("req_o", |req_i, req_o);
        req_i = req_i & ~gnt_s;                              // Pixel drops its request
    endtask

    task automatic quiet_cycles(input int n, input logic rel_exp);
        repeat (n)
        begin
            step();
            check_gnt("gnt_o while quiet", '0, gnt_s);
            check_bit("grp_release_o", rel_exp, rel_s);
        end
    endtask

    task automatic wait_grant();
        int n;
        n = 0;
        step();
        while (gnt_s == '0)
        begin
            n++;
            if (n > WAIT_MAX)
                abort_run($sformatf("Timeout in %s: the next pixel grant never came", test_name));
            step();
        end
    endtask

    task automatic wait_release();
        int n;
        n = 0;
        step();
        while (!rel_s)
        begin
            check_gnt("gnt_o after last grant", '0, gnt_s);
            n++;
            if (n > WAIT_MAX)
                abort_run($sformatf("Timeout in %s: grp_release_o never rose", test_name));
            step();
        end
    endtask

    // Rows ascending, columns ascending, each row at most once per pass
    task automatic build_model();
        gnt_mat_t                     pat;
        logic [ROWS-1:0]              served;
        int                           cur;
        int                           g;
        int                           guard;
        bit                           hit;
        lib_arbiter_pkg::pixel_addr_t a;
        pat = start_pat;
        served = '0;
        cur = -1;
        g = 0;
        guard = 0;
        model_q.delete();
        pass_end.delete();
        while (pat != '0 && guard < 500)
        begin
            guard++;
            hit = 1'b0;
            for (int c = 0; c < COLS && cur >= 0; c++)
                if (!hit && pat[cur][c])
                begin
                    hit = 1'b1;
                    a.x = cur[AW-1:0];
                    a.y = c[AW-1:0];
                end
            if (!hit)
            begin
                if (cur >= 0)
                    served[cur] = 1'b1;                      // Row finished for this pass
                cur = -1;
                for (int r = 0; r < ROWS; r++)
                    if (cur < 0 && !served[r] && pat[r] != '0)
                        cur = r;
                if (cur < 0)
                begin
                    pass_end.push_back(g);                   // Leftovers wait for a new pass
                    served = '0;
                end
                continue;
            end
            model_q.push_back(a);
            pat[a.x][a.y] = 1'b0;
            g++;
            foreach (late_at[k])
                if (late_at[k] == g)
                    pat = pat | late_pat[k];
            if (g == drop_at)
            begin
                served = '0;                                 // Enable drop restarts the pass
                cur = -1;
            end
        end
        pass_end.push_back(g);
    endtask

    task automatic run_scenario();
        int g;
        int p;
        build_model();
        if (model_q.size() != exp_q.size())
            abort_run($sformatf("Trace of %s lists %0d grants but the serving rule gives %0d",
                                test_name, exp_q.size(), model_q.size()));
        foreach (exp_q[i])
            check_addr($sformatf("trace entry %0d against rule", i), model_q[i], exp_q[i]);
        req_i = start_pat;
        quiet_cycles(3, 1'b0);
        enable_i = 1'b1;
        g = 0;
        p = 0;
        while (g < exp_q.size())
        begin
            wait_grant();
            check_gnt($sformatf("gnt_o of grant %0d", g), onehot_of(exp_q[g]), gnt_s);
            check_addr($sformatf("addr_o of grant %0d", g), exp_q[g], addr_s);
            check_bit("grp_release_o during pass", 1'b0, rel_s);
            g++;
            foreach (late_at[k])
                if (late_at[k] == g)
                    req_i = req_i | late_pat[k];             // Late pixels raise requests
            if (g == drop_at)
            begin
                enable_i = 1'b0;
                quiet_cycles(3, 1'b0);
                enable_i = 1'b1;
            end
            else if (g == pass_end[p])
            begin
                p++;
                wait_release();
                quiet_cycles(4, 1'b1);                       // Release holds with no stray grant
                enable_i = 1'b0;
                quiet_cycles(3, 1'b0);
                if (g < exp_q.size())
                    enable_i = 1'b1;                         // Next pass for waiting pixels
            end
        end
    endtask

    initial
    begin
        int                           fd;
        int                           rc;
        int                           n_tests;
        int                           r;
        int                           c;
        int                           cnt;
        string                        line;
        string                        key;
        gnt_mat_t                     pat;
        lib_arbiter_pkg::pixel_addr_t a;
        clk_i = 1'b0;
        reset_i = 1'b1;
        enable_i = 1'b0;
        req_i = '0;
        gnt_s = '0;
        test_name = "reset";
        quiet_cycles(4, 1'b0);                               // Reset held for 4 cycles
        reset_i = 1'b0;
        quiet_cycles(2, 1'b0);
        fd = $fopen("tests/pixel_level_0_trace.txt", "r");
        if (fd == 0)
            abort_run("Trace file tests/pixel_level_0_trace.txt could not be opened");
        n_tests = 0;
        while (!$feof(fd))
        begin
            line = "";
            rc = $fgets(line, fd);
            if ($sscanf(line, "%s", key) != 1)
                continue;                                    // Blank line
            if (key == "test")
            begin
                rc = $sscanf(line, "test %s", test_name);
                start_pat = '0;
                drop_at = 0;
                late_at.delete();
                late_pat.delete();
                exp_q.delete();
            end
            else if (key == "req")
                rc = $sscanf(line, "req %h", start_pat);
            else if (key == "late")
            begin
                rc = $sscanf(line, "late %d %h", cnt, pat);
                late_at.push_back(cnt);
                late_pat.push_back(pat);
            end
            else if (key == "drop")
                rc = $sscanf(line, "drop %d", drop_at);
            else if (key == "a")
            begin
                rc = $sscanf(line, "a %d %d", r, c);
                a.x = r[AW-1:0];
                a.y = c[AW-1:0];
                exp_q.push_back(a);
            end
            else if (key == "end")
            begin
                run_scenario();
                n_tests++;
            end
        end
        $fclose(fd);
        if (n_tests == 0)
            abort_run("Trace file held no complete scenario");
        $display("Done: no errors");
        $finish;
    end

endmodule

/* tests/pixel_level_0_trace.txt */
# Keys: test <name> | req <hex pixel pattern, bit 4*row+col> | late <after grant n> <hex pattern>
# drop <after grant n, 0 none> | a <row> <col> is the next expected grant | end runs the scenario
test single_pixel
req 0040
drop 0
a 1 2
end
test full_group
req ffff
drop 0
a 0 0
a 0 1
a 0 2
a 0 3
a 1 0
a 1 1
a 1 2
a 1 3
a 2 0
a 2 1
a 2 2
a 2 3
a 3 0
a 3 1
a 3 2
a 3 3
end
test late_requests
req 0812
late 2 4008
drop 0
a 0 1
a 1 0
a 2 3
a 3 2
a 0 3
end
test enable_drop
req 8703
drop 3
a 0 0
a 0 1
a 2 0
a 2 1
a 2 2
a 3 3
end
